//--- verilog/mips_pkg.sv
package mips_pkg;

	////////////////////////////////////////////////////////////////////
	// Instruction-set widths
	////////////////////////////////////////////////////////////////////

	localparam int word_width = 32;
	localparam int reg_addr_width = 5;
	localparam int field_width = 6;
	localparam int imm_width = 16;
	localparam int index_width = 26;

	typedef logic [word_width-1:0] word_t;
	typedef logic [reg_addr_width-1:0] reg_addr_t;
	typedef logic [reg_addr_width-1:0] shamt_t;
	typedef logic [field_width-1:0] opcode_t;
	typedef logic [field_width-1:0] funct_t;
	typedef logic [imm_width-1:0] imm_t;
	typedef logic [index_width-1:0] jump_index_t;
	typedef logic [3:0] alu_op_t;

	// Primary opcodes
	localparam opcode_t op_rtype = 6'h00;
	localparam opcode_t op_j = 6'h02;
	localparam opcode_t op_jal = 6'h03;
	localparam opcode_t op_beq = 6'h04;
	localparam opcode_t op_bne = 6'h05;
	localparam opcode_t op_addi = 6'h08;
	localparam opcode_t op_andi = 6'h0c;
	localparam opcode_t op_ori = 6'h0d;
	localparam opcode_t op_lui = 6'h0f;
	localparam opcode_t op_lw = 6'h23;
	localparam opcode_t op_sw = 6'h2b;
	localparam opcode_t op_halt = 6'h3f;

	// R-type function field
	localparam funct_t fn_sll = 6'h00;
	localparam funct_t fn_srl = 6'h02;
	localparam funct_t fn_jr = 6'h08;
	localparam funct_t fn_jalr = 6'h09;
	localparam funct_t fn_add = 6'h20;
	localparam funct_t fn_sub = 6'h22;
	localparam funct_t fn_and = 6'h24;
	localparam funct_t fn_or = 6'h25;
	localparam funct_t fn_slt = 6'h2a;

	// ALU operations
	// Add is zero so an empty group means add
	localparam alu_op_t alu_add = 4'd0;
	localparam alu_op_t alu_sub = 4'd1;
	localparam alu_op_t alu_and = 4'd2;
	localparam alu_op_t alu_or = 4'd3;
	localparam alu_op_t alu_slt = 4'd4;
	localparam alu_op_t alu_sll = 4'd5;
	localparam alu_op_t alu_srl = 4'd6;
	localparam alu_op_t alu_lui = 4'd7;

endpackage

//--- verilog/pipe_pkg.sv
package pipe_pkg;

	import mips_pkg::*;

	////////////////////////////////////////////////////////////////////
	// Control groups carried down the pipeline
	////////////////////////////////////////////////////////////////////

	// Execute stage controls
	typedef struct packed {
		logic reg_dst;
		logic alu_src;
		alu_op_t alu_op;
		logic shift;
		logic branch_eq;
		logic branch_ne;
		logic jump;
		logic jump_register;
		logic link;
	} exec_ctrl_t;

	// Memory stage controls
	typedef struct packed {
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	// Write-back stage controls
	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	////////////////////////////////////////////////////////////////////
	// Stage registers and ports
	////////////////////////////////////////////////////////////////////

	// Decode to execute register
	typedef struct packed {
		word_t pc_branch;
		word_t sign_ext;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		shamt_t shamt;
		exec_ctrl_t exec;
		mem_ctrl_t mem;
		wb_ctrl_t wb;
		logic halt;
	} id_ex_t;

	// Write request coming back from write-back
	typedef struct packed {
		logic reg_write;
		reg_addr_t write_register;
		word_t write_data;
	} wb_port_t;

	// Run controller
	typedef enum logic [1:0] {
		st_stopped,
		st_running,
		st_step
	} run_state_t;

endpackage

//--- verilog/control_unit.sv
`timescale 1ns/1ps

module control_unit
	import mips_pkg::*;
	import pipe_pkg::*;
(
	input opcode_t opcode,
	input funct_t funct,
	output exec_ctrl_t exec,
	output mem_ctrl_t mem,
	output wb_ctrl_t wb
);

	always_comb
	begin
		exec = '0;
		mem = '0;
		wb = '0;

		case (opcode)
			op_rtype:
			begin
				// Register-register ops write rd
				case (funct)
					fn_add:
					begin
						exec.reg_dst = 1'b1;
						exec.alu_op = alu_add;
						wb.reg_write = 1'b1;
					end
					fn_sub:
					begin
						exec.reg_dst = 1'b1;
						exec.alu_op = alu_sub;
						wb.reg_write = 1'b1;
					end
					fn_and:
					begin
						exec.reg_dst = 1'b1;
						exec.alu_op = alu_and;
						wb.reg_write = 1'b1;
					end
					fn_or:
					begin
						exec.reg_dst = 1'b1;
						exec.alu_op = alu_or;
						wb.reg_write = 1'b1;
					end
					fn_slt:
					begin
						exec.reg_dst = 1'b1;
						exec.alu_op = alu_slt;
						wb.reg_write = 1'b1;
					end
					fn_sll, fn_srl:
					begin
						exec.reg_dst = 1'b1;
						exec.shift = 1'b1;
						exec.alu_op = (funct == fn_sll) ? alu_sll : alu_srl;
						wb.reg_write = 1'b1;
					end
					fn_jr:
						exec.jump_register = 1'b1;
					fn_jalr:
					begin
						// Link address goes to rd
						exec.reg_dst = 1'b1;
						exec.jump_register = 1'b1;
						exec.link = 1'b1;
						wb.reg_write = 1'b1;
					end
					default: ;
				endcase
			end
			op_j:
				exec.jump = 1'b1;
			op_jal:
			begin
				exec.jump = 1'b1;
				exec.link = 1'b1;
				wb.reg_write = 1'b1;
			end
			op_beq, op_bne:
			begin
				// Compare by subtraction
				exec.alu_op = alu_sub;
				exec.branch_eq = (opcode == op_beq);
				exec.branch_ne = (opcode == op_bne);
			end
			op_addi, op_andi, op_ori, op_lui:
			begin
				exec.alu_src = 1'b1;
				wb.reg_write = 1'b1;
				case (opcode)
					op_andi: exec.alu_op = alu_and;
					op_ori: exec.alu_op = alu_or;
					op_lui: exec.alu_op = alu_lui;
					default: exec.alu_op = alu_add;
				endcase
			end
			op_lw:
			begin
				exec.alu_src = 1'b1;
				mem.mem_read = 1'b1;
				wb.reg_write = 1'b1;
				wb.mem_to_reg = 1'b1;
			end
			op_sw:
			begin
				exec.alu_src = 1'b1;
				mem.mem_write = 1'b1;
			end
			// Halt and unknown opcodes leave everything clear
			default: ;
		endcase
	end

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ps

module register_file
	import mips_pkg::*;
	import pipe_pkg::*;
#(
	parameter int reg_count = 32
)(
	input logic clk,
	input logic reset,
	input logic enable,
	input reg_addr_t read_addr_1,
	input reg_addr_t read_addr_2,
	input wb_port_t wb_in,
	output word_t read_data_1,
	output word_t read_data_2,
	output word_t read_now_1
);

	word_t regs [reg_count];
	logic write_hit;
	word_t now_1;
	word_t now_2;

	// Register 0 is never written
	assign write_hit = enable && wb_in.reg_write && (wb_in.write_register != '0);

	// Write-through so a same-cycle write is seen by the reader
	always_comb
	begin
		if (read_addr_1 == '0)
			now_1 = '0;
		else if (write_hit && (wb_in.write_register == read_addr_1))
			now_1 = wb_in.write_data;
		else
			now_1 = regs[read_addr_1];

		if (read_addr_2 == '0)
			now_2 = '0;
		else if (write_hit && (wb_in.write_register == read_addr_2))
			now_2 = wb_in.write_data;
		else
			now_2 = regs[read_addr_2];
	end

	assign read_now_1 = now_1;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
			read_data_1 <= '0;
			read_data_2 <= '0;
		end
		else if (enable)
		begin
			if (write_hit)
				regs[wb_in.write_register] <= wb_in.write_data;
			read_data_1 <= now_1;
			read_data_2 <= now_2;
		end
	end

endmodule

//--- verilog/run_controller.sv
`timescale 1ns/1ps

module run_controller
	import pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic run,
	input logic step,
	input logic halt_seen,
	output logic stage_enable
);

	run_state_t state;
	run_state_t next_state;

	always_comb
	begin
		next_state = state;
		case (state)
			st_stopped:
			begin
				// A halt sitting in id_ex blocks free running
				if (run && !halt_seen)
					next_state = st_running;
				else if (step)
					next_state = st_step;
			end
			st_running:
			begin
				if (!run || halt_seen)
					next_state = st_stopped;
			end
			st_step:
				next_state = st_stopped;
			default:
				next_state = st_stopped;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= st_stopped;
		else
			state <= next_state;
	end

	// Halt gates the enable at once so halted stays up
	assign stage_enable = (state == st_step) ||
		((state == st_running) && !halt_seen);

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
	import mips_pkg::*;
	import pipe_pkg::*;
#(
	parameter int reg_count = 32
)(
	input logic clk,
	input logic reset,
	input logic enable,
	input logic flush,
	input word_t pc_branch_in,
	input word_t instruction,
	input wb_port_t wb_in,
	output id_ex_t id_ex,
	output word_t reg1,
	output word_t reg2,
	output word_t pc_jump,
	output word_t pc_jump_register,
	output logic jump,
	output logic jump_register,
	output logic stall
);

	////////////////////////////////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////////////////////////////////

	opcode_t opcode;
	funct_t funct;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	shamt_t shamt;
	imm_t imm;
	jump_index_t index;

	assign opcode = instruction[31:26];
	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];
	assign shamt = instruction[10:6];
	assign funct = instruction[5:0];
	assign imm = instruction[15:0];
	assign index = instruction[25:0];

	exec_ctrl_t dec_exec;
	mem_ctrl_t dec_mem;
	wb_ctrl_t dec_wb;
	word_t rs_now;
	logic hazard;
	logic is_halt;
	id_ex_t next_id_ex;

	control_unit u_control (
		.opcode(opcode),
		.funct(funct),
		.exec(dec_exec),
		.mem(dec_mem),
		.wb(dec_wb)
	);

	register_file #(
		.reg_count(reg_count)
	) u_registers (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.read_addr_1(rs),
		.read_addr_2(rt),
		.wb_in(wb_in),
		.read_data_1(reg1),
		.read_data_2(reg2),
		.read_now_1(rs_now)
	);

	// Load-use against the instruction now in execute
	assign hazard = id_ex.mem.mem_read && ((id_ex.rt == rs) || (id_ex.rt == rt));
	assign is_halt = (opcode == op_halt);

	////////////////////////////////////////////////////////////////////
	// Combinational outputs
	////////////////////////////////////////////////////////////////////

	assign stall = flush ? 1'b0 : hazard;
	assign jump = flush ? 1'b0 : dec_exec.jump;
	assign jump_register = flush ? 1'b0 : dec_exec.jump_register;
	assign pc_jump = flush ? '0 : {pc_branch_in[31:28], index, 2'b00};
	assign pc_jump_register = flush ? '0 : rs_now;

	////////////////////////////////////////////////////////////////////
	// Decode to execute register
	////////////////////////////////////////////////////////////////////

	always_comb
	begin
		next_id_ex = '0;
		// Halt is passed on even through a flush
		next_id_ex.halt = is_halt;
		if (!flush)
		begin
			next_id_ex.pc_branch = pc_branch_in;
			next_id_ex.sign_ext = word_t'($signed(imm));
			next_id_ex.rs = rs;
			next_id_ex.rt = rt;
			next_id_ex.rd = rd;
			next_id_ex.shamt = shamt;
			// Bubble on a hazard
			if (!hazard)
			begin
				next_id_ex.exec = dec_exec;
				next_id_ex.mem = dec_mem;
				next_id_ex.wb = dec_wb;
			end
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			id_ex <= '0;
		else if (enable)
			id_ex <= next_id_ex;
	end

endmodule

//--- verilog/decode_top.sv
`timescale 1ns/1ps

module decode_top
	import mips_pkg::*;
	import pipe_pkg::*;
#(
	parameter int reg_count = 32
)(
	input logic clk,
	input logic reset,
	input logic run,
	input logic step,
	input logic flush,
	input word_t pc_branch_in,
	input word_t instruction,
	input wb_port_t wb_in,
	output id_ex_t id_ex,
	output word_t reg1,
	output word_t reg2,
	output word_t pc_jump,
	output word_t pc_jump_register,
	output logic jump,
	output logic jump_register,
	output logic stall,
	output logic stage_enable,
	output logic halted
);

	assign halted = id_ex.halt;

	run_controller u_run (
		.clk(clk),
		.reset(reset),
		.run(run),
		.step(step),
		.halt_seen(id_ex.halt),
		.stage_enable(stage_enable)
	);

	decode_stage #(
		.reg_count(reg_count)
	) u_decode (
		.clk(clk),
		.reset(reset),
		.enable(stage_enable),
		.flush(flush),
		.pc_branch_in(pc_branch_in),
		.instruction(instruction),
		.wb_in(wb_in),
		.id_ex(id_ex),
		.reg1(reg1),
		.reg2(reg2),
		.pc_jump(pc_jump),
		.pc_jump_register(pc_jump_register),
		.jump(jump),
		.jump_register(jump_register),
		.stall(stall)
	);

endmodule

//--- bench/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Reference model of the decode stage and run controller
//////////////////////////////////////////////////////////////////////

word_t shadow [32];
id_ex_t m_id_ex;
word_t m_reg1;
word_t m_reg2;
run_state_t m_state;

// Expected control groups with one equation per field
function automatic void decode_groups(input word_t instr, output exec_ctrl_t e,
	output mem_ctrl_t m, output wb_ctrl_t w);
	opcode_t op;
	funct_t fn;
	logic rtype;
	op = instr[31:26];
	fn = instr[5:0];
	rtype = (op == op_rtype);
	e = '0;
	m = '0;
	w = '0;
	// Every known R-type except jr writes rd
	e.reg_dst = rtype && (fn inside {fn_add, fn_sub, fn_and, fn_or, fn_slt,
		fn_sll, fn_srl, fn_jalr});
	e.alu_src = op inside {op_addi, op_andi, op_ori, op_lui, op_lw, op_sw};
	e.shift = rtype && (fn inside {fn_sll, fn_srl});
	e.branch_eq = (op == op_beq);
	e.branch_ne = (op == op_bne);
	e.jump = op inside {op_j, op_jal};
	e.jump_register = rtype && (fn inside {fn_jr, fn_jalr});
	e.link = (op == op_jal) || (rtype && fn == fn_jalr);
	if (op inside {op_beq, op_bne} || (rtype && fn == fn_sub))
		e.alu_op = alu_sub;
	else if (op == op_andi || (rtype && fn == fn_and))
		e.alu_op = alu_and;
	else if (op == op_ori || (rtype && fn == fn_or))
		e.alu_op = alu_or;
	else if (op == op_lui)
		e.alu_op = alu_lui;
	else if (rtype && fn == fn_slt)
		e.alu_op = alu_slt;
	else if (rtype && fn == fn_sll)
		e.alu_op = alu_sll;
	else if (rtype && fn == fn_srl)
		e.alu_op = alu_srl;
	m.mem_read = (op == op_lw);
	m.mem_write = (op == op_sw);
	w.reg_write = e.reg_dst || (op inside {op_addi, op_andi, op_ori, op_lui, op_lw, op_jal});
	w.mem_to_reg = (op == op_lw);
endfunction

// Register read with write-through and a hard-wired zero
function automatic word_t read_port(input reg_addr_t a, input logic en, input wb_port_t wb);
	if (a == 5'd0)
		return '0;
	if (en && wb.reg_write && wb.write_register == a)
		return wb.write_data;
	return shadow[a];
endfunction

function automatic logic load_use(input word_t instr);
	return m_id_ex.mem.mem_read &&
		(m_id_ex.rt == instr[25:21] || m_id_ex.rt == instr[20:16]);
endfunction

// Halt in execute holds the pipeline at once
function automatic logic stage_enabled();
	return (m_state == st_step) || (m_state == st_running && !m_id_ex.halt);
endfunction

function automatic id_ex_t expected_id_ex(input word_t instr, input word_t pc, input logic fl);
	id_ex_t n;
	exec_ctrl_t e;
	mem_ctrl_t m;
	wb_ctrl_t w;
	n = '0;
	n.halt = (instr[31:26] == op_halt);
	if (!fl)
	begin
		n.pc_branch = pc;
		n.sign_ext = {{16{instr[15]}}, instr[15:0]};
		n.rs = instr[25:21];
		n.rt = instr[20:16];
		n.rd = instr[15:11];
		n.shamt = instr[10:6];
		if (!load_use(instr))
		begin
			decode_groups(instr, e, m, w);
			n.exec = e;
			n.mem = m;
			n.wb = w;
		end
	end
	return n;
endfunction

// One rising edge with the inputs that were held during the cycle
task automatic advance_model(input word_t instr, input word_t pc, input logic fl,
	input wb_port_t wb, input logic rn, input logic st);
	logic en;
	run_state_t nxt;
	en = stage_enabled();
	nxt = st_stopped;
	if (m_state == st_stopped)
		nxt = (rn && !m_id_ex.halt) ? st_running : (st ? st_step : st_stopped);
	else if (m_state == st_running)
		nxt = (!rn || m_id_ex.halt) ? st_stopped : st_running;
	if (en)
	begin
		m_reg1 = read_port(instr[25:21], 1'b1, wb);
		m_reg2 = read_port(instr[20:16], 1'b1, wb);
		m_id_ex = expected_id_ex(instr, pc, fl);
		if (wb.reg_write && wb.write_register != 5'd0)
			shadow[wb.write_register] = wb.write_data;
	end
	m_state = nxt;
endtask

task automatic clear_model();
	for (int i = 0; i < 32; i++)
		shadow[i] = '0;
	m_id_ex = '0;
	m_reg1 = '0;
	m_reg2 = '0;
	m_state = st_stopped;
endtask

`endif

//--- bench/decode_tb.sv
`timescale 1ns/1ps

module decode_tb
	import mips_pkg::*;
	import pipe_pkg::*;
();

	logic clk;
	logic reset;
	logic run;
	logic step;
	logic flush;
	word_t pc_branch_in;
	word_t instruction;
	wb_port_t wb_in;
	id_ex_t id_ex;
	word_t reg1;
	word_t reg2;
	word_t pc_jump;
	word_t pc_jump_register;
	logic jump;
	logic jump_register;
	logic stall;
	logic stage_enable;
	logic halted;

	// Inputs as last driven
	word_t cur_instr;
	word_t cur_pc;
	logic cur_flush;
	wb_port_t cur_wb;
	logic cur_run;
	logic cur_step;
	logic run_req;

	int errors;
	int test_base;
	int tests;
	logic abort_run;

	// Supported opcodes and functions
	// R-type weighted up
	localparam opcode_t op_pool [16] = '{op_rtype, op_rtype, op_rtype, op_j, op_jal, op_beq,
		op_bne, op_addi, op_andi, op_ori, op_lui, op_lw, op_lw, op_sw, op_addi, op_ori};
	localparam funct_t fn_pool [16] = '{fn_add, fn_sub, fn_and, fn_or, fn_slt, fn_sll,
		fn_srl, fn_jr, fn_jalr, fn_add, fn_sub, fn_and, fn_or, fn_slt, fn_sll, fn_srl};
	// sll r0, r0, 0
	localparam word_t idle_instr = 32'h0000_0000;
	localparam word_t halt_instr = {op_halt, 26'd0};

	`include "decode_model.svh"

	decode_top #(
		.reg_count(32)
	) uut (
		.clk(clk),
		.reset(reset),
		.run(run),
		.step(step),
		.flush(flush),
		.pc_branch_in(pc_branch_in),
		.instruction(instruction),
		.wb_in(wb_in),
		.id_ex(id_ex),
		.reg1(reg1),
		.reg2(reg2),
		.pc_jump(pc_jump),
		.pc_jump_register(pc_jump_register),
		.jump(jump),
		.jump_register(jump_register),
		.stall(stall),
		.stage_enable(stage_enable),
		.halted(halted)
	);

	always #2 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_id_ex(input string name, input id_ex_t got, input id_ex_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Cycle driver and full output check
	//////////////////////////////////////////////////////////////////////

	task compare_outputs();
		exec_ctrl_t e;
		mem_ctrl_t m;
		wb_ctrl_t w;
		logic en;
		en = stage_enabled();
		decode_groups(cur_instr, e, m, w);
		check_bit("stage_enable", stage_enable, en);
		check_bit("halted", halted, m_id_ex.halt);
		check_id_ex("id_ex", id_ex, m_id_ex);
		check_word("reg1", reg1, m_reg1);
		check_word("reg2", reg2, m_reg2);
		check_bit("stall", stall, !cur_flush && load_use(cur_instr));
		check_bit("jump", jump, !cur_flush && e.jump);
		check_bit("jump_register", jump_register, !cur_flush && e.jump_register);
		check_word("pc_jump", pc_jump,
			cur_flush ? '0 : {cur_pc[31:28], cur_instr[25:0], 2'b00});
		check_word("pc_jump_register", pc_jump_register,
			cur_flush ? '0 : read_port(cur_instr[25:21], en, cur_wb));
	endtask

	// Edge, then new inputs, then a check at the falling edge
	task clock_cycle(input word_t instr, input word_t pc, input logic fl, input wb_port_t wb,
		input logic st);
		@(posedge clk);
		advance_model(cur_instr, cur_pc, cur_flush, cur_wb, cur_run, cur_step);
		instruction <= instr;
		pc_branch_in <= pc;
		flush <= fl;
		wb_in <= wb;
		step <= st;
		run <= run_req;
		cur_instr = instr;
		cur_pc = pc;
		cur_flush = fl;
		cur_wb = wb;
		cur_step = st;
		cur_run = run_req;
		@(negedge clk);
		compare_outputs();
	endtask

	function automatic wb_port_t write_req(input reg_addr_t a, input word_t d);
		wb_port_t w;
		w.reg_write = 1'b1;
		w.write_register = a;
		w.write_data = d;
		return w;
	endfunction

	function automatic wb_port_t random_wb();
		wb_port_t w;
		word_t r;
		r = $urandom;
		w = write_req(r[4:0], $urandom);
		w.reg_write = r[5];
		return w;
	endfunction

	// Random fields under a supported opcode but never a halt
	function automatic word_t random_instr();
		word_t r;
		word_t pick;
		r = $urandom;
		pick = $urandom;
		r[31:26] = op_pool[pick[3:0]];
		if (r[31:26] == op_rtype)
			r[5:0] = fn_pool[pick[7:4]];
		return r;
	endfunction

	task report_timeout(input string what);
		errors++;
		$display("Timeout while %s", what);
		abort_run = 1'b1;
	endtask

	task wait_enable(input logic level, input string what);
		int count;
		count = 0;
		while (stage_enable !== level && count < 16)
		begin
			clock_cycle(idle_instr, '0, 1'b0, '0, 1'b0);
			count++;
		end
		if (stage_enable !== level)
			report_timeout(what);
	endtask

	task report_test(input string name);
		tests++;
		$display("Test %s: %s, %0d errors", name, (errors == test_base) ? "ok" : "FAILED",
			errors - test_base);
		test_base = errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task register_readback();
		word_t r;
		wb_port_t wb;
		reg_addr_t rs;
		reg_addr_t rt;
		for (int i = 0; i < 40; i++)
		begin
			r = $urandom;
			rs = (r[12:10] == 3'd0) ? 5'd0 : r[4:0];
			rt = r[9:5];
			wb = write_req(r[15:11], $urandom);
			wb.reg_write = r[16] | r[17];
			// Same-cycle hits on either read port
			if (r[19:18] == 2'd0)
				wb.write_register = rs;
			else if (r[19:18] == 2'd1)
				wb.write_register = rt;
			clock_cycle({op_rtype, rs, rt, r[24:20], 5'd0, fn_add}, 32'h0040_0000, 1'b0,
				wb, 1'b0);
		end
		report_test("register readback");
	endtask

	task random_decode();
		for (int i = 0; i < 60; i++)
			clock_cycle(random_instr(), $urandom, 1'b0, random_wb(), 1'b0);
		report_test("random decode");
	endtask

	task load_use_stall();
		word_t r;
		word_t dep;
		reg_addr_t ld_rt;
		reg_addr_t other_1;
		reg_addr_t other_2;
		for (int i = 0; i < 8; i++)
		begin
			r = $urandom;
			ld_rt = r[4:0];
			other_1 = ld_rt + 5'd1;
			other_2 = ld_rt + 5'd2;
			dep = r[10] ? {op_rtype, ld_rt, r[15:11], 5'd3, 5'd0, fn_add} :
				{op_rtype, r[15:11], ld_rt, 5'd3, 5'd0, fn_add};
			clock_cycle(idle_instr, '0, 1'b0, '0, 1'b0);
			clock_cycle({op_lw, r[9:5], ld_rt, r[31:16]}, '0, 1'b0, '0, 1'b0);
			clock_cycle(dep, '0, 1'b0, '0, 1'b0);
			check_bit("stall", stall, 1'b1);
			clock_cycle(idle_instr, '0, 1'b0, '0, 1'b0);
			check_bit("id_ex.wb.reg_write", id_ex.wb.reg_write, 1'b0);
			// Load again, then a follower that uses neither register
			clock_cycle({op_lw, r[9:5], ld_rt, r[31:16]}, '0, 1'b0, '0, 1'b0);
			clock_cycle({op_rtype, other_1, other_2, 5'd3, 5'd0, fn_or}, '0, 1'b0, '0, 1'b0);
			check_bit("stall", stall, 1'b0);
		end
		report_test("load-use stall");
	endtask

	task flush_clearing();
		for (int i = 0; i < 12; i++)
		begin
			clock_cycle(random_instr(), $urandom, 1'b1, random_wb(), 1'b0);
			check_word("pc_jump", pc_jump, '0);
			check_bit("stall", stall, 1'b0);
			clock_cycle(random_instr(), $urandom, 1'b0, '0, 1'b0);
			check_id_ex("id_ex", id_ex, '0);
		end
		report_test("flush");
	endtask

	task jump_targets();
		word_t r;
		word_t data;
		word_t pc;
		reg_addr_t target;
		for (int i = 0; i < 8; i++)
		begin
			r = $urandom;
			data = $urandom;
			pc = $urandom;
			target = (r[4:0] == 5'd0) ? 5'd9 : r[4:0];
			clock_cycle(idle_instr, pc, 1'b0, write_req(target, data), 1'b0);
			clock_cycle({op_j, r[30:5]}, pc, 1'b0, '0, 1'b0);
			check_bit("jump", jump, 1'b1);
			clock_cycle({op_jal, data[25:0]}, pc, 1'b0, '0, 1'b0);
			clock_cycle({op_rtype, target, 15'd0, fn_jr}, pc, 1'b0, '0, 1'b0);
			check_bit("jump_register", jump_register, 1'b1);
			check_word("pc_jump_register", pc_jump_register, data);
		end
		report_test("jump targets");
	endtask

	task step_and_halt();
		word_t instr;
		word_t pc;
		int count;
		run_req = 1'b0;
		wait_enable(1'b0, "waiting for the pipeline to stop");
		for (int i = 0; i < 8; i++)
		begin
			instr = random_instr();
			pc = $urandom;
			// Only the middle instruction lands in id_ex
			clock_cycle(random_instr(), $urandom, 1'b0, '0, 1'b1);
			clock_cycle(instr, pc, 1'b0, '0, 1'b0);
			clock_cycle(random_instr(), $urandom, 1'b0, '0, 1'b0);
			check_bit("stage_enable", stage_enable, 1'b0);
			check_word("id_ex.pc_branch", id_ex.pc_branch, pc);
		end
		run_req = 1'b1;
		wait_enable(1'b1, "waiting for the pipeline to resume");
		count = 0;
		while (halted !== 1'b1 && count < 16)
		begin
			clock_cycle(halt_instr, '0, 1'b0, '0, 1'b0);
			count++;
		end
		if (halted !== 1'b1)
			report_timeout("waiting for halted");
		// Run stays high but the pipeline must stay frozen
		repeat (6)
		begin
			clock_cycle(random_instr(), $urandom, 1'b0, random_wb(), 1'b0);
			check_bit("stage_enable", stage_enable, 1'b0);
			check_bit("halted", halted, 1'b1);
		end
		report_test("step and halt");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(32'h69c6f557));
		clk = 1'b0;
		reset = 1'b1;
		run = 1'b0;
		step = 1'b0;
		flush = 1'b0;
		pc_branch_in = '0;
		instruction = '0;
		wb_in = '0;
		cur_instr = '0;
		cur_pc = '0;
		cur_flush = 1'b0;
		cur_wb = '0;
		cur_run = 1'b0;
		cur_step = 1'b0;
		run_req = 1'b0;
		errors = 0;
		test_base = 0;
		tests = 0;
		abort_run = 1'b0;
		clear_model();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		clock_cycle(idle_instr, '0, 1'b0, '0, 1'b0);

		run_req = 1'b1;
		wait_enable(1'b1, "waiting for the pipeline to start");
		register_readback();
		random_decode();
		load_use_stall();
		flush_clearing();
		jump_targets();
		step_and_halt();

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Ends the run after a timeout
	initial
	begin
		wait (abort_run);
		$display("Verification failed");
		$finish;
	end

endmodule

//--- tb.f
+incdir+bench
verilog/mips_pkg.sv
verilog/pipe_pkg.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/run_controller.sv
verilog/decode_stage.sv
verilog/decode_top.sv
bench/decode_tb.sv

//--- Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP ?= decode_tb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The output is kept in a shell variable and searched for the pass message
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
